// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	// --------------------------------------------------
	// cpu bus geometry
	// --------------------------------------------------
	localparam int BUS_DW = 32;
	localparam int BUS_SW = 4;

	// region nibble at the top of the address
	localparam int REGION_HI = 31;
	localparam int REGION_LO = 28;
	localparam logic [REGION_HI-REGION_LO:0] REGION_MISC = 4'h2;

	// returned for any access outside the misc region
	localparam logic [BUS_DW-1:0] BUS_ERR_RDATA = 32'hDEAD_BEEF;

	// --------------------------------------------------
	// interrupt vector layout
	// --------------------------------------------------
	// bits 0 to 2 belong to the cpu core itself
	localparam int IRQ_BUS_ERR = 3;
	localparam int IRQ_EXT_BASE = 4;
	localparam int IRQ_EXT_N = 3;

endpackage

`default_nettype wire

// ==== sysctl_pkg.sv ====
`default_nettype none

package sysctl_pkg;

	// --------------------------------------------------
	// misc register map, word index from addr[6:2]
	// --------------------------------------------------
	localparam int REG_IDX_W = 5;
	localparam int REG_IDX_LO = 2;

	localparam logic [REG_IDX_W-1:0] REG_LED = 5'd0;
	localparam logic [REG_IDX_W-1:0] REG_BTN = 5'd1;
	localparam logic [REG_IDX_W-1:0] REG_SOC_VER = 5'd2;
	localparam logic [REG_IDX_W-1:0] REG_FLASH_SEL = 5'd13;
	localparam logic [REG_IDX_W-1:0] REG_GENIO_IN = 5'd17;
	localparam logic [REG_IDX_W-1:0] REG_GENIO_OUT = 5'd18;
	localparam logic [REG_IDX_W-1:0] REG_GENIO_OE = 5'd19;
	localparam logic [REG_IDX_W-1:0] REG_GENIO_W2S = 5'd20;
	localparam logic [REG_IDX_W-1:0] REG_GENIO_W2C = 5'd21;
	localparam logic [REG_IDX_W-1:0] REG_GPEXT_IN = 5'd22;
	localparam logic [REG_IDX_W-1:0] REG_GPEXT_OUT = 5'd23;
	localparam logic [REG_IDX_W-1:0] REG_GPEXT_OE = 5'd24;
	localparam logic [REG_IDX_W-1:0] REG_GPEXT_W2S = 5'd25;
	localparam logic [REG_IDX_W-1:0] REG_GPEXT_W2C = 5'd26;

	// pin group widths
	localparam int LED_W = 16;
	localparam int LED_PINS = 9;
	localparam int BTN_W = 8;
	localparam int GENIO_W = 30;
	localparam int SAO_W = 6;
	localparam int PMOD_W = 8;

	localparam logic [31:0] SOC_VERSION = 32'h0000_0000;

	// upper 24 bits of a flash select write that trigger an fpga reload
	localparam logic [23:0] RELOAD_KEY = 24'hD0F1A5;

	// --------------------------------------------------
	// flash select sequencer timing
	// --------------------------------------------------
	localparam int FSEL_DLY_W = 3;
	localparam logic [FSEL_DLY_W-1:0] FSEL_DELAY_INIT = 3'd7;
	// mux clock high while the count is in [FSEL_C_LAST, FSEL_C_FIRST]
	localparam logic [FSEL_DLY_W-1:0] FSEL_C_FIRST = 3'd5;
	localparam logic [FSEL_DLY_W-1:0] FSEL_C_LAST = 3'd3;
	localparam logic [FSEL_DLY_W-1:0] FSEL_RELOAD_CNT = 3'd1;

	// extension port word, bit 30 is usb_vdet on read of IN, irda_sd on OUT
	typedef struct packed {
		logic              spare;
		logic              aux;
		logic [5:0]        pad_hi;
		logic [PMOD_W-1:0] pmod;
		logic [1:0]        pad_mid;
		logic [SAO_W-1:0]  sao2;
		logic [1:0]        pad_lo;
		logic [SAO_W-1:0]  sao1;
	} gpext_fields_t;

	typedef struct packed {
		logic [1:0]         pad;
		logic [GENIO_W-1:0] genio;
	} genio_fields_t;

	typedef union packed {
		gpext_fields_t ext;
		genio_fields_t gen;
	} gpext_word_u;

endpackage

`default_nettype wire

// ==== bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
	input  wire                                clk48m,
	input  wire                                rst,
	input  wire                                mem_valid_i,
	input  wire  [bus_pkg::BUS_DW-1:0]         mem_addr_i,
	input  wire  [bus_pkg::BUS_DW-1:0]         misc_rdata_i,
	input  wire  [bus_pkg::IRQ_EXT_N-1:0]      irq_ext_i,
	output logic                               misc_sel_o,
	output logic                               mem_ready_o,
	output logic [bus_pkg::BUS_DW-1:0]         mem_rdata_o,
	output logic [bus_pkg::BUS_DW-1:0]         irq_o
);

	import bus_pkg::*;

	logic [REGION_HI-REGION_LO:0] region;
	logic                         is_misc;
	logic                         bus_err;

	// --------------------------------------------------
	// region decode
	// --------------------------------------------------
	assign region = mem_addr_i[REGION_HI:REGION_LO];
	assign is_misc = (region == REGION_MISC);

	assign misc_sel_o = mem_valid_i && is_misc;
	// nothing else lives on this bus, so any other region is an error
	assign bus_err = mem_valid_i && !is_misc;

	// both targets answer in the same cycle
	assign mem_ready_o = misc_sel_o || bus_err;
	assign mem_rdata_o = is_misc ? misc_rdata_i : BUS_ERR_RDATA;

	// --------------------------------------------------
	// interrupt vector
	// --------------------------------------------------
	always_comb begin
		irq_o = '0;
		irq_o[IRQ_BUS_ERR] = bus_err;
		irq_o[IRQ_EXT_BASE +: IRQ_EXT_N] = irq_ext_i;
	end

endmodule

`default_nettype wire

// ==== sysctl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sysctl_regs (
	input  wire                                 clk48m,
	input  wire                                 rst,
	input  wire                                 misc_sel_i,
	input  wire  [bus_pkg::BUS_DW-1:0]          mem_addr_i,
	input  wire  [bus_pkg::BUS_DW-1:0]          mem_wdata_i,
	input  wire  [bus_pkg::BUS_SW-1:0]          mem_wstrb_i,
	input  wire  [sysctl_pkg::BTN_W-1:0]        btn_i,
	input  wire  [sysctl_pkg::GENIO_W-1:0]      genio_i,
	input  wire  [sysctl_pkg::SAO_W-1:0]        sao1_i,
	input  wire  [sysctl_pkg::SAO_W-1:0]        sao2_i,
	input  wire  [sysctl_pkg::PMOD_W-1:0]       pmod_i,
	input  wire                                 usb_vdet_i,
	input  wire  [sysctl_pkg::GENIO_W-1:0]      genio_out_i,
	input  wire  [sysctl_pkg::GENIO_W-1:0]      genio_oe_i,
	input  wire  sysctl_pkg::gpext_word_u       gpext_out_i,
	input  wire  sysctl_pkg::gpext_word_u       gpext_oe_i,
	output logic [bus_pkg::BUS_DW-1:0]          misc_rdata_o,
	output logic                                gpio_we_o,
	output logic [sysctl_pkg::REG_IDX_W-1:0]    gpio_idx_o,
	output logic [sysctl_pkg::LED_PINS-1:0]     led_o,
	output logic                                trace_en_o,
	output logic                                fsel_d_o,
	output logic                                fsel_strobe_o,
	output logic                                reload_req_o
);

	import bus_pkg::*;
	import sysctl_pkg::*;

	logic [REG_IDX_W-1:0] reg_idx;
	logic                 wr_en;
	logic [LED_W-1:0]     led_q;
	gpext_word_u          gpext_in;

	// genio registers read back zero extended through the genio view
	function automatic gpext_word_u genio_word(input logic [GENIO_W-1:0] val);
		gpext_word_u w;
		w = '0;
		w.gen.genio = val;
		return w;
	endfunction

	assign reg_idx = mem_addr_i[REG_IDX_LO +: REG_IDX_W];
	assign wr_en = misc_sel_i && mem_wstrb_i[0];

	// io port registers are held in gpio_port
	assign gpio_we_o = wr_en;
	assign gpio_idx_o = reg_idx;

	// only 9 of the 16 led bits are wired to pins
	assign led_o = {led_q[10:8], led_q[5:0]};

	// --------------------------------------------------
	// register writes
	// --------------------------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_q <= '0;
			trace_en_o <= 1'b0;
			fsel_d_o <= 1'b0;
			fsel_strobe_o <= 1'b0;
			reload_req_o <= 1'b0;
		end else begin
			fsel_strobe_o <= 1'b0;
			if (wr_en) begin
				case (reg_idx)
					REG_LED: led_q <= mem_wdata_i[LED_W-1:0];
					REG_SOC_VER: trace_en_o <= mem_wdata_i[0];
					REG_FLASH_SEL: begin
						fsel_d_o <= mem_wdata_i[0];
						fsel_strobe_o <= 1'b1;
						// key in the top bits arms the reload, sticky until reset
						if (mem_wdata_i[BUS_DW-1:8] == RELOAD_KEY) begin
							reload_req_o <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// readback
	// --------------------------------------------------
	always_comb begin
		gpext_in = '0;
		gpext_in.ext.aux = usb_vdet_i;
		gpext_in.ext.pmod = pmod_i;
		gpext_in.ext.sao2 = sao2_i;
		gpext_in.ext.sao1 = sao1_i;
	end

	always_comb begin
		misc_rdata_o = '0;
		case (reg_idx)
			REG_LED:       misc_rdata_o[LED_W-1:0] = led_q;
			// buttons are active low on the board
			REG_BTN:       misc_rdata_o[BTN_W-1:0] = ~btn_i;
			REG_SOC_VER:   misc_rdata_o = SOC_VERSION;
			REG_FLASH_SEL: misc_rdata_o[0] = fsel_d_o;
			REG_GENIO_IN:  misc_rdata_o = genio_word(genio_i);
			REG_GENIO_OUT: misc_rdata_o = genio_word(genio_out_i);
			REG_GENIO_OE:  misc_rdata_o = genio_word(genio_oe_i);
			REG_GPEXT_IN:  misc_rdata_o = gpext_in;
			REG_GPEXT_OUT: misc_rdata_o = gpext_out_i;
			REG_GPEXT_OE:  misc_rdata_o = gpext_oe_i;
			default:       misc_rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== gpio_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
	input  wire                                clk48m,
	input  wire                                rst,
	input  wire                                gpio_we_i,
	input  wire  [sysctl_pkg::REG_IDX_W-1:0]   gpio_idx_i,
	input  wire  [bus_pkg::BUS_DW-1:0]         mem_wdata_i,
	output logic [sysctl_pkg::GENIO_W-1:0]     genio_o,
	output logic [sysctl_pkg::GENIO_W-1:0]     genio_oe_o,
	output logic [sysctl_pkg::SAO_W-1:0]       sao1_o,
	output logic [sysctl_pkg::SAO_W-1:0]       sao1_oe_o,
	output logic [sysctl_pkg::SAO_W-1:0]       sao2_o,
	output logic [sysctl_pkg::SAO_W-1:0]       sao2_oe_o,
	output logic [sysctl_pkg::PMOD_W-1:0]      pmod_o,
	output logic [sysctl_pkg::PMOD_W-1:0]      pmod_oe_o,
	output logic                               irda_sd_o
);

	import sysctl_pkg::*;

	gpext_word_u wd;

	assign wd = mem_wdata_i;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			genio_o <= '0;
			genio_oe_o <= '0;
			sao1_o <= '0;
			sao1_oe_o <= '0;
			sao2_o <= '0;
			sao2_oe_o <= '0;
			pmod_o <= '0;
			pmod_oe_o <= '0;
			// irda transceiver starts shut down
			irda_sd_o <= 1'b1;
		end else if (gpio_we_i) begin
			case (gpio_idx_i)
				// --------------------------------------------------
				// general io
				// --------------------------------------------------
				REG_GENIO_OUT: genio_o <= wd.gen.genio;
				REG_GENIO_OE:  genio_oe_o <= wd.gen.genio;
				REG_GENIO_W2S: genio_o <= genio_o | wd.gen.genio;
				REG_GENIO_W2C: genio_o <= genio_o & ~wd.gen.genio;

				// --------------------------------------------------
				// extension ports
				// --------------------------------------------------
				REG_GPEXT_OUT: begin
					irda_sd_o <= wd.ext.aux;
					pmod_o <= wd.ext.pmod;
					sao2_o <= wd.ext.sao2;
					sao1_o <= wd.ext.sao1;
				end
				// irda_sd is output only
				REG_GPEXT_OE: begin
					pmod_oe_o <= wd.ext.pmod;
					sao2_oe_o <= wd.ext.sao2;
					sao1_oe_o <= wd.ext.sao1;
				end
				REG_GPEXT_W2S: begin
					irda_sd_o <= irda_sd_o | wd.ext.aux;
					pmod_o <= pmod_o | wd.ext.pmod;
					sao2_o <= sao2_o | wd.ext.sao2;
					sao1_o <= sao1_o | wd.ext.sao1;
				end
				REG_GPEXT_W2C: begin
					irda_sd_o <= irda_sd_o & ~wd.ext.aux;
					pmod_o <= pmod_o & ~wd.ext.pmod;
					sao2_o <= sao2_o & ~wd.ext.sao2;
					sao1_o <= sao1_o & ~wd.ext.sao1;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== reload_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reload_sequencer (
	input  wire  clk48m,
	input  wire  rst,
	input  wire  fsel_strobe_i,
	input  wire  reload_req_i,
	output logic fsel_c_o,
	output logic programn_o
);

	import sysctl_pkg::*;

	logic [FSEL_DLY_W-1:0] fsel_dly;
	logic [FSEL_DLY_W-1:0] dly_next;
	logic                  fpga_reload;

	assign dly_next = fsel_dly - 1'b1;

	// give fsel_d time to settle before clocking the flash mux flop
	assign fsel_c_o = (fsel_dly <= FSEL_C_FIRST) && (fsel_dly >= FSEL_C_LAST);

	assign programn_o = ~fpga_reload;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_dly <= '0;
			fpga_reload <= 1'b0;
		end else if (fsel_strobe_i) begin
			fsel_dly <= FSEL_DELAY_INIT;
		end else if (fsel_dly != '0) begin
			fsel_dly <= dly_next;
			// mux clock is done by now, reload holds until reset
			if (dly_next == FSEL_RELOAD_CNT && reload_req_i) begin
				fpga_reload <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sysctl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sysctl_top (
	input  wire                                clk48m,
	input  wire                                rst,
	// cpu bus
	input  wire                                mem_valid_i,
	input  wire  [bus_pkg::BUS_DW-1:0]         mem_addr_i,
	input  wire  [bus_pkg::BUS_DW-1:0]         mem_wdata_i,
	input  wire  [bus_pkg::BUS_SW-1:0]         mem_wstrb_i,
	output wire                                mem_ready_o,
	output wire  [bus_pkg::BUS_DW-1:0]         mem_rdata_o,
	input  wire  [bus_pkg::IRQ_EXT_N-1:0]      irq_ext_i,
	output wire  [bus_pkg::BUS_DW-1:0]         irq_o,
	// board io
	input  wire  [sysctl_pkg::BTN_W-1:0]       btn_i,
	output wire  [sysctl_pkg::LED_PINS-1:0]    led_o,
	output wire                                trace_en_o,
	input  wire  [sysctl_pkg::GENIO_W-1:0]     genio_i,
	output wire  [sysctl_pkg::GENIO_W-1:0]     genio_o,
	output wire  [sysctl_pkg::GENIO_W-1:0]     genio_oe_o,
	input  wire  [sysctl_pkg::SAO_W-1:0]       sao1_i,
	output wire  [sysctl_pkg::SAO_W-1:0]       sao1_o,
	output wire  [sysctl_pkg::SAO_W-1:0]       sao1_oe_o,
	input  wire  [sysctl_pkg::SAO_W-1:0]       sao2_i,
	output wire  [sysctl_pkg::SAO_W-1:0]       sao2_o,
	output wire  [sysctl_pkg::SAO_W-1:0]       sao2_oe_o,
	input  wire  [sysctl_pkg::PMOD_W-1:0]      pmod_i,
	output wire  [sysctl_pkg::PMOD_W-1:0]      pmod_o,
	output wire  [sysctl_pkg::PMOD_W-1:0]      pmod_oe_o,
	input  wire                                usb_vdet_i,
	output wire                                irda_sd_o,
	// flash select and reconfiguration
	output wire                                fsel_c_o,
	output wire                                fsel_d_o,
	output wire                                programn_o
);

	import bus_pkg::*;
	import sysctl_pkg::*;

	wire                 misc_sel;
	wire [BUS_DW-1:0]    misc_rdata;
	wire                 gpio_we;
	wire [REG_IDX_W-1:0] gpio_idx;
	wire                 fsel_strobe;
	wire                 reload_req;

	bus_decoder u_bus_decoder (
		.clk48m       (clk48m),
		.rst          (rst),
		.mem_valid_i  (mem_valid_i),
		.mem_addr_i   (mem_addr_i),
		.misc_rdata_i (misc_rdata),
		.irq_ext_i    (irq_ext_i),
		.misc_sel_o   (misc_sel),
		.mem_ready_o  (mem_ready_o),
		.mem_rdata_o  (mem_rdata_o),
		.irq_o        (irq_o)
	);

	sysctl_regs u_sysctl_regs (
		.clk48m        (clk48m),
		.rst           (rst),
		.misc_sel_i    (misc_sel),
		.mem_addr_i    (mem_addr_i),
		.mem_wdata_i   (mem_wdata_i),
		.mem_wstrb_i   (mem_wstrb_i),
		.btn_i         (btn_i),
		.genio_i       (genio_i),
		.sao1_i        (sao1_i),
		.sao2_i        (sao2_i),
		.pmod_i        (pmod_i),
		.usb_vdet_i    (usb_vdet_i),
		.genio_out_i   (genio_o),
		.genio_oe_i    (genio_oe_o),
		// extension state packed into its register layout
		.gpext_out_i   (gpext_fields_t'{aux: irda_sd_o, pmod: pmod_o, sao2: sao2_o,
			sao1: sao1_o, default: '0}),
		.gpext_oe_i    (gpext_fields_t'{pmod: pmod_oe_o, sao2: sao2_oe_o,
			sao1: sao1_oe_o, default: '0}),
		.misc_rdata_o  (misc_rdata),
		.gpio_we_o     (gpio_we),
		.gpio_idx_o    (gpio_idx),
		.led_o         (led_o),
		.trace_en_o    (trace_en_o),
		.fsel_d_o      (fsel_d_o),
		.fsel_strobe_o (fsel_strobe),
		.reload_req_o  (reload_req)
	);

	gpio_port u_gpio_port (
		.clk48m      (clk48m),
		.rst         (rst),
		.gpio_we_i   (gpio_we),
		.gpio_idx_i  (gpio_idx),
		.mem_wdata_i (mem_wdata_i),
		.genio_o     (genio_o),
		.genio_oe_o  (genio_oe_o),
		.sao1_o      (sao1_o),
		.sao1_oe_o   (sao1_oe_o),
		.sao2_o      (sao2_o),
		.sao2_oe_o   (sao2_oe_o),
		.pmod_o      (pmod_o),
		.pmod_oe_o   (pmod_oe_o),
		.irda_sd_o   (irda_sd_o)
	);

	reload_sequencer u_reload_sequencer (
		.clk48m        (clk48m),
		.rst           (rst),
		.fsel_strobe_i (fsel_strobe),
		.reload_req_i  (reload_req),
		.fsel_c_o      (fsel_c_o),
		.programn_o    (programn_o)
	);

endmodule

`default_nettype wire

// ==== tb_sysctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sysctl;

	import bus_pkg::*;
	import sysctl_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 5;
	localparam int BUS_TIMEOUT = 16;
	localparam logic [31:0] MISC_BASE = 32'h2000_0000;
	localparam logic [31:0] ERR_WORD = 32'hDEAD_BEEF;
	localparam logic [23:0] KEY = 24'hD0F1A5;
	// cycle budget per test, summed for the watchdog
	localparam int TEST_CYCLES = 10 + 80 + 400 + 40 + 60 + 60;
	localparam int MARGIN_CYCLES = 200;

	logic        clk48m;
	logic        rst;
	logic        mem_valid;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	wire         mem_ready;
	wire  [31:0] mem_rdata;
	logic [2:0]  irq_ext;
	wire  [31:0] irq;
	logic [7:0]  btn;
	wire  [8:0]  led;
	wire         trace_en;
	logic [29:0] genio_in;
	wire  [29:0] genio_out;
	wire  [29:0] genio_oe;
	logic [5:0]  sao1_in;
	wire  [5:0]  sao1_out;
	wire  [5:0]  sao1_oe;
	logic [5:0]  sao2_in;
	wire  [5:0]  sao2_out;
	wire  [5:0]  sao2_oe;
	logic [7:0]  pmod_in;
	wire  [7:0]  pmod_out;
	wire  [7:0]  pmod_oe;
	logic        usb_vdet;
	wire         irda_sd;
	wire         fsel_c;
	wire         fsel_d;
	wire         programn;

	logic [31:0] lfsr_q = 32'h6b1a;

	// expected port state for the set and clear test
	logic [29:0] m_genio;
	logic [29:0] m_genio_oe;
	logic        m_aux;
	logic [7:0]  m_pmod;
	logic [5:0]  m_sao2;
	logic [5:0]  m_sao1;
	logic [7:0]  m_pmod_oe;
	logic [5:0]  m_sao2_oe;
	logic [5:0]  m_sao1_oe;

	sysctl_top u_sysctl_top (
		.clk48m      (clk48m),
		.rst         (rst),
		.mem_valid_i (mem_valid),
		.mem_addr_i  (mem_addr),
		.mem_wdata_i (mem_wdata),
		.mem_wstrb_i (mem_wstrb),
		.mem_ready_o (mem_ready),
		.mem_rdata_o (mem_rdata),
		.irq_ext_i   (irq_ext),
		.irq_o       (irq),
		.btn_i       (btn),
		.led_o       (led),
		.trace_en_o  (trace_en),
		.genio_i     (genio_in),
		.genio_o     (genio_out),
		.genio_oe_o  (genio_oe),
		.sao1_i      (sao1_in),
		.sao1_o      (sao1_out),
		.sao1_oe_o   (sao1_oe),
		.sao2_i      (sao2_in),
		.sao2_o      (sao2_out),
		.sao2_oe_o   (sao2_oe),
		.pmod_i      (pmod_in),
		.pmod_o      (pmod_out),
		.pmod_oe_o   (pmod_oe),
		.usb_vdet_i  (usb_vdet),
		.irda_sd_o   (irda_sd),
		.fsel_c_o    (fsel_c),
		.fsel_d_o    (fsel_d),
		.programn_o  (programn)
	);

	initial begin
		clk48m = 1'b0;
		forever #(CLK_PERIOD / 2) clk48m = ~clk48m;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
			stop_run("stopping at the first mismatch");
		end
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] reg_addr(input logic [4:0] idx);
		return MISC_BASE | {25'd0, idx, 2'b00};
	endfunction

	// extension word layout with bit 30 and pmod, sao2 and sao1 in place
	function automatic logic [31:0] ext_word(input logic aux, input logic [7:0] pmod,
		input logic [5:0] sao2, input logic [5:0] sao1);
		return {1'b0, aux, 6'b0, pmod, 2'b0, sao2, 2'b0, sao1};
	endfunction

	task automatic wait_ready(input string what);
		int n;
		n = 0;
		@(negedge clk48m);
		while (!mem_ready) begin
			n++;
			if (n > BUS_TIMEOUT) begin
				stop_run({what, " never saw ready"});
			end
			@(negedge clk48m);
		end
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		@(posedge clk48m);
		#DRIVE_DLY;
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = data;
		mem_wstrb = strb;
		wait_ready("bus write");
		// write lands on this edge
		@(posedge clk48m);
		#DRIVE_DLY;
		mem_valid = 1'b0;
		mem_wstrb = '0;
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
		output logic [31:0] irq_seen);
		@(posedge clk48m);
		#DRIVE_DLY;
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wstrb = '0;
		wait_ready("bus read");
		data = mem_rdata;
		irq_seen = irq;
		@(posedge clk48m);
		#DRIVE_DLY;
		mem_valid = 1'b0;
	endtask

	task automatic read_check(input string what, input logic [4:0] idx,
		input logic [31:0] exp);
		logic [31:0] data;
		logic [31:0] irq_seen;
		bus_read(reg_addr(idx), data, irq_seen);
		check_eq(what, data, exp);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic test_reset_values();
		check_eq("led after reset", led, 0);
		check_eq("trace_en after reset", trace_en, 0);
		check_eq("fsel_c after reset", fsel_c, 0);
		check_eq("fsel_d after reset", fsel_d, 0);
		check_eq("genio out after reset", genio_out, 0);
		check_eq("genio oe after reset", genio_oe, 0);
		check_eq("sao1 after reset", {sao1_out, sao1_oe}, 0);
		check_eq("sao2 after reset", {sao2_out, sao2_oe}, 0);
		check_eq("pmod after reset", {pmod_out, pmod_oe}, 0);
		check_eq("irda_sd after reset", irda_sd, 1);
		check_eq("programn after reset", programn, 1);
		check_eq("ready while idle", mem_ready, 0);
	endtask

	task automatic test_plain_regs();
		logic [31:0] w;
		logic [7:0]  b;
		for (int i = 0; i < 8; i++) begin
			w = rand_bits(32);
			bus_write(reg_addr(REG_LED), w, 4'hF);
			check_eq("led pins", led, {w[10:8], w[5:0]});
			read_check("led readback", REG_LED, {16'd0, w[15:0]});
		end
		// strobe bit 0 clear means no write
		bus_write(reg_addr(REG_LED), ~w, 4'b0010);
		check_eq("led after masked strobe", led, {w[10:8], w[5:0]});
		read_check("version", REG_SOC_VER, 32'h0);
		bus_write(reg_addr(REG_SOC_VER), 32'h1, 4'hF);
		check_eq("trace_en set", trace_en, 1);
		bus_write(reg_addr(REG_SOC_VER), 32'h0, 4'hF);
		check_eq("trace_en clear", trace_en, 0);
		for (int i = 0; i < 4; i++) begin
			b = rand_bits(8);
			btn = b;
			read_check("buttons inverted", REG_BTN, {24'd0, ~b});
		end
		read_check("unlisted index 7", 5'd7, 32'h0);
		read_check("unlisted index 31", 5'd31, 32'h0);
	endtask

	task automatic check_ports();
		check_eq("genio out", genio_out, m_genio);
		check_eq("genio oe", genio_oe, m_genio_oe);
		check_eq("irda_sd", irda_sd, m_aux);
		check_eq("pmod out", pmod_out, m_pmod);
		check_eq("sao2 out", sao2_out, m_sao2);
		check_eq("sao1 out", sao1_out, m_sao1);
		check_eq("ext oe", {pmod_oe, sao2_oe, sao1_oe}, {m_pmod_oe, m_sao2_oe, m_sao1_oe});
		read_check("genio out readback", REG_GENIO_OUT, {2'b0, m_genio});
		read_check("genio oe readback", REG_GENIO_OE, {2'b0, m_genio_oe});
		read_check("ext out readback", REG_GPEXT_OUT, ext_word(m_aux, m_pmod, m_sao2, m_sao1));
		read_check("ext oe readback", REG_GPEXT_OE, ext_word(0, m_pmod_oe, m_sao2_oe, m_sao1_oe));
	endtask

	// write one io register and follow it in the model
	task automatic gpio_op(input logic [4:0] idx, input logic [31:0] w);
		bus_write(reg_addr(idx), w, 4'hF);
		case (idx)
			REG_GENIO_OUT: m_genio = w[29:0];
			REG_GENIO_OE:  m_genio_oe = w[29:0];
			REG_GENIO_W2S: m_genio = m_genio | w[29:0];
			REG_GENIO_W2C: m_genio = m_genio & ~w[29:0];
			REG_GPEXT_OUT: {m_aux, m_pmod, m_sao2, m_sao1} = {w[30], w[23:16], w[13:8], w[5:0]};
			REG_GPEXT_OE:  {m_pmod_oe, m_sao2_oe, m_sao1_oe} = {w[23:16], w[13:8], w[5:0]};
			REG_GPEXT_W2S: begin
				{m_aux, m_pmod} = {m_aux, m_pmod} | {w[30], w[23:16]};
				{m_sao2, m_sao1} = {m_sao2, m_sao1} | {w[13:8], w[5:0]};
			end
			REG_GPEXT_W2C: begin
				{m_aux, m_pmod} = {m_aux, m_pmod} & ~{w[30], w[23:16]};
				{m_sao2, m_sao1} = {m_sao2, m_sao1} & ~{w[13:8], w[5:0]};
			end
			default: ;
		endcase
	endtask

	task automatic test_set_clear();
		{m_genio, m_genio_oe} = '0;
		{m_aux, m_pmod, m_sao2, m_sao1} = {1'b1, 20'd0};
		{m_pmod_oe, m_sao2_oe, m_sao1_oe} = '0;
		gpio_op(REG_GENIO_OUT, rand_bits(32));
		gpio_op(REG_GENIO_OE, rand_bits(32));
		gpio_op(REG_GPEXT_OUT, rand_bits(32));
		gpio_op(REG_GPEXT_OE, rand_bits(32));
		check_ports();
		for (int i = 0; i < 6; i++) begin
			gpio_op(REG_GENIO_W2S, rand_bits(32));
			gpio_op(REG_GPEXT_W2S, rand_bits(32));
			check_ports();
			gpio_op(REG_GENIO_W2C, rand_bits(32));
			gpio_op(REG_GPEXT_W2C, rand_bits(32));
			check_ports();
		end
		// input side through the same word layout
		for (int i = 0; i < 3; i++) begin
			genio_in = rand_bits(30);
			{usb_vdet, pmod_in, sao2_in, sao1_in} = rand_bits(21);
			read_check("genio in", REG_GENIO_IN, {2'b0, genio_in});
			read_check("ext in", REG_GPEXT_IN, ext_word(usb_vdet, pmod_in, sao2_in, sao1_in));
		end
	endtask

	task automatic test_bus_error();
		logic [3:0]  region;
		logic [2:0]  ext;
		logic [27:0] offs;
		logic [31:0] data;
		logic [31:0] irq_seen;
		for (int i = 0; i < 8; i++) begin
			region = rand_bits(4);
			if (region == 4'h2) begin
				region = 4'h3;
			end
			ext = rand_bits(3);
			irq_ext = ext;
			offs = rand_bits(28);
			bus_read({region, offs}, data, irq_seen);
			check_eq("error read data", data, ERR_WORD);
			check_eq("irq during error", irq_seen, {25'd0, ext, 4'b1000});
			@(negedge clk48m);
			check_eq("irq after error", irq, {25'd0, ext, 4'b0000});
		end
		bus_read(reg_addr(REG_LED), data, irq_seen);
		check_eq("irq during misc access", irq_seen, {25'd0, irq_ext, 4'b0000});
	endtask

	// counts cycles after the accepting edge and checks the strobe window
	task automatic flash_select(input logic [23:0] top, input logic d, input logic keyed);
		logic prog_low;
		prog_low = !programn;
		bus_write(reg_addr(REG_FLASH_SEL), {top, 7'd0, d}, 4'hF);
		check_eq("fsel_d", fsel_d, d);
		for (int k = 0; k < 10; k++) begin
			@(negedge clk48m);
			check_eq("fsel_c window", fsel_c, (k >= 3 && k <= 5));
			check_eq("programn", programn, !(prog_low || (keyed && k >= 7)));
		end
		read_check("flash select readback", REG_FLASH_SEL, {31'd0, d});
	endtask

	task automatic test_fsel_plain();
		logic [23:0] top;
		for (int i = 0; i < 2; i++) begin
			top = rand_bits(24);
			if (top == KEY) begin
				top[0] = ~top[0];
			end
			flash_select(top, (i == 0), 1'b0);
		end
	endtask

	task automatic test_fsel_key();
		flash_select(KEY, 1'b1, 1'b1);
		// reload stays latched through a later unkeyed write
		flash_select(24'h0, 1'b0, 1'b0);
	endtask

	// --------------------------------------------------
	// main sequence and watchdog
	// --------------------------------------------------
	initial begin
		rst = 1'b1;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		irq_ext = '0;
		btn = '0;
		genio_in = '0;
		sao1_in = '0;
		sao2_in = '0;
		pmod_in = '0;
		usb_vdet = 1'b0;
		repeat (2) @(posedge clk48m);
		#DRIVE_DLY;
		rst = 1'b0;
		test_reset_values();
		test_plain_regs();
		test_set_clear();
		test_bus_error();
		test_fsel_plain();
		test_fsel_key();
		$display("Test OK");
		$finish;
	end

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		stop_run("watchdog timeout, the tests did not finish in time");
	end

endmodule

`default_nettype wire

// ==== tb.f ====
bus_pkg.sv
sysctl_pkg.sv
bus_decoder.sv
sysctl_regs.sv
gpio_port.sv
reload_sequencer.sv
sysctl_top.sv
tb_sysctl.sv

// ==== Bender.yml ====
package:
  name: sysctl

sources:
  - bus_pkg.sv
  - sysctl_pkg.sv
  - bus_decoder.sv
  - sysctl_regs.sv
  - gpio_port.sv
  - reload_sequencer.sv
  - sysctl_top.sv
  - target: simulation
    files:
      - tb_sysctl.sv
